/* build.f */
+incdir+include
source/icache_pkg.sv
source/refill_if.sv
source/icache_ctrl.sv
source/refill_counter.sv
source/tag_array.sv
source/data_array.sv
source/icache_top.sv
test/icache_properties.sv
test/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb -f build.f -o icache_sim

sim_out=$(./obj_dir/icache_sim +verilator+error+limit+100) || true
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* test/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_tb;

    // Tests take roughly two hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // A, B and C share set 8, P and Q share set 20
    localparam logic [63:0] ADDR_A = 64'h0000_0000_0000_1040;
    localparam logic [63:0] ADDR_B = 64'h0000_0000_0000_3040;
    localparam logic [63:0] ADDR_C = 64'h0000_0000_0000_5044;
    localparam logic [63:0] ADDR_P = 64'h0000_0000_0002_00a0;
    localparam logic [63:0] ADDR_Q = 64'hfedc_ba98_7654_20a0;

    logic        clk;
    logic        flush = 1'b0;
    logic        valid_in = 1'b0;
    logic [63:0] pc = '0;
    logic        valid_out;
    logic [31:0] inst;
    logic        busy;
    logic        mem_req;
    logic [63:0] mem_addr;
    logic        mem_valid = 1'b0;
    logic [31:0] mem_rdata = '0;

    logic [31:0] rng_state = 32'h4643_b2c9;
    int          mem_beat = 0;
    int          mem_wait = 0;
    bit          line_done = 1'b0;
    bit          mem_req_prev = 1'b0;
    int          refill_count = 0;
    int          beat_count = 0;
    int          cycle_count = 0;
    // Address seen when the last refill request went out
    logic [63:0] req_addr = '0;

    icache_top icache_top_inst (
        .clk       (clk),
        .flush     (flush),
        .valid_in  (valid_in),
        .pc        (pc),
        .valid_out (valid_out),
        .inst      (inst),
        .busy      (busy),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // Contents of external memory at a word address
    function automatic logic [31:0] memory_word(input logic [63:0] byte_addr);
        return byte_addr[31:0] ^ 32'hc0de_0000;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected)
        else fail_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    endtask

    // External memory, beats after 0 to 3 idle cycles each
    always @(posedge clk) begin
        mem_valid <= 1'b0;
        if (!mem_req) begin
            mem_beat  = 0;
            line_done = 1'b0;
            rng_state = xorshift32(rng_state);
            mem_wait  = int'(rng_state[1:0]);
        end else if (!line_done) begin
            if (mem_wait != 0) begin
                mem_wait--;
            end else begin
                mem_valid <= 1'b1;
                mem_rdata <= memory_word(mem_addr + 64'(mem_beat * 4));
                mem_beat++;
                rng_state = xorshift32(rng_state);
                mem_wait  = int'(rng_state[1:0]);
                line_done = (mem_beat == `ICACHE_BEATS);
            end
        end
    end

    always @(posedge clk) begin
        if (mem_req && !mem_req_prev) begin
            refill_count++;
            req_addr = mem_addr;
        end
        if (mem_req && mem_valid) begin
            beat_count++;
        end
        mem_req_prev = mem_req;
    end

    always @(negedge clk) begin
        assert (icache_top_inst.icache_properties_inst.violations == 0)
        else fail_run("A bound property on the DUT ports failed");
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        fail_run($sformatf("Timeout after %0d cycles, the tests did not finish",
                           TIMEOUT_CYCLES));
    end

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b0;
        repeat (16) @(posedge clk);
        flush <= 1'b1;
        // Two synchronizer flops before the cache leaves reset
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic fetch(input string name, input logic [63:0] addr, input bit expect_hit);
        int          refills_before;
        int          beats_before;
        int          latency;
        bit          busy_seen;
        logic [31:0] expected;
        expected       = memory_word({addr[63:2], 2'b00});
        refills_before = refill_count;
        beats_before   = beat_count;
        latency        = 0;
        busy_seen      = 1'b0;
        @(posedge clk);
        valid_in <= 1'b1;
        pc       <= addr;
        @(posedge clk);
        valid_in <= 1'b0;
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            busy_seen = busy_seen || busy;
        end while (!valid_out);
        check_value({name, " inst"}, 64'(expected), 64'(inst));
        // Busy drops together with the answer
        check_value({name, " busy at answer"}, 64'd0, 64'(busy));
        if (expect_hit) begin
            check_value({name, " latency"}, 64'd1, 64'(latency));
            check_value({name, " refills"}, 64'd0, 64'(refill_count - refills_before));
            check_value({name, " busy"}, 64'd0, 64'(busy_seen));
        end else begin
            check_value({name, " refills"}, 64'd1, 64'(refill_count - refills_before));
            check_value({name, " beats"}, 64'(`ICACHE_BEATS), 64'(beat_count - beats_before));
            check_value({name, " busy"}, 64'd1, 64'(busy_seen));
            check_value({name, " mem_addr"}, {addr[63:3], 3'b000}, req_addr);
        end
    endtask

    task automatic cold_miss();
        fetch("cold_miss", ADDR_A, 1'b0);
    endtask

    task automatic repeat_hit();
        fetch("repeat_hit", ADDR_A, 1'b1);
    endtask

    task automatic other_word_hit();
        fetch("other_word_hit", ADDR_A ^ 64'h4, 1'b1);
    endtask

    task automatic fill_both_ways();
        fetch("fill_both_ways P fill", ADDR_P, 1'b0);
        fetch("fill_both_ways Q fill", ADDR_Q, 1'b0);
        fetch("fill_both_ways P hit", ADDR_P, 1'b1);
        fetch("fill_both_ways Q hit", ADDR_Q, 1'b1);
    endtask

    // A is touched last, so C must push B out
    task automatic lru_eviction();
        fetch("lru_eviction B fill", ADDR_B, 1'b0);
        fetch("lru_eviction A touch", ADDR_A, 1'b1);
        fetch("lru_eviction C fill", ADDR_C, 1'b0);
        fetch("lru_eviction A kept", ADDR_A, 1'b1);
        fetch("lru_eviction B evicted", ADDR_B, 1'b0);
    endtask

    task automatic flush_clears_lines();
        apply_flush();
        fetch("flush_clears_lines", ADDR_A, 1'b0);
    endtask

    initial begin
        apply_flush();
        cold_miss();
        repeat_hit();
        other_word_hit();
        fill_both_ways();
        lru_eviction();
        flush_clears_lines();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* test/icache_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input logic        clk,
    input logic        flush,
    input logic        valid_out,
    input logic        busy,
    input logic        mem_req,
    input logic [63:0] mem_addr
);

    // Failed properties so far
    int violations = 0;

    // Refill address holds for the whole request
    addr_stable: assert property (@(posedge clk) disable iff (!flush)
        (mem_req && $past(mem_req)) |-> (mem_addr == $past(mem_addr)))
    else begin
        violations++;
        $error("mem_addr changed while mem_req was high");
    end

    single_pulse: assert property (@(posedge clk) disable iff (!flush)
        !(valid_out && $past(valid_out)))
    else begin
        violations++;
        $error("valid_out stayed high for two cycles");
    end

    quiet_in_flush: assert property (@(posedge clk)
        !flush |-> (!valid_out && !busy && !mem_req))
    else begin
        violations++;
        $error("An output was active while flush was low");
    end

endmodule

bind icache_top icache_properties icache_properties_inst (
    .clk       (clk),
    .flush     (flush),
    .valid_out (valid_out),
    .busy      (busy),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr)
);

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      flush,
    input  logic                      valid_in,
    input  logic [63:0]               pc,
    output logic                      valid_out,
    output logic [`ICACHE_WORD_W-1:0] inst,
    output logic                      busy,
    output logic                      mem_req,
    output logic [63:0]               mem_addr,
    input  logic                      mem_valid,
    input  logic [`ICACHE_WORD_W-1:0] mem_rdata
);

    logic        rst_meta_q;
    logic        rst_n;
    fetch_addr_t pc_addr;
    fetch_addr_t addr_q;
    logic        lookup_q;
    logic        accept;
    logic        hit;
    logic        hit_way;
    logic        victim_way;

    refill_if refill ();

    // Flush asserts at once, its release goes through two flops
    always_ff @(posedge clk or negedge flush) begin
        if (!flush) begin
            rst_meta_q <= 1'b0;
            rst_n      <= 1'b0;
        end else begin
            rst_meta_q <= 1'b1;
            rst_n      <= rst_meta_q;
        end
    end

    assign pc_addr = fetch_addr_t'(pc);

    // Controller is idle when neither busy nor looking up
    assign accept = valid_in && !busy && !lookup_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= accept;
        end
    end

    // Held through a miss so index and tag stay put
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= pc_addr;
        end
    end

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .addr       (addr_q),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .busy       (busy),
        .valid_out  (valid_out),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_rdata  (mem_rdata),
        .refill     (refill.ctrl)
    );

    refill_counter u_refill_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .refill (refill.counter)
    );

    tag_array u_tag_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (addr_q.f.index),
        .tag        (addr_q.f.tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .touch      (lookup_q),
        .refill     (refill.array)
    );

    data_array u_data_array (
        .clk      (clk),
        .index    (addr_q.f.index),
        .hit_way  (hit_way),
        .word_sel (addr_q.f.offset[`ICACHE_OFFSET_W-1 -: `ICACHE_BEAT_SEL_W]),
        .inst     (inst),
        .refill   (refill.array)
    );

endmodule

`default_nettype wire

/* source/data_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module data_array (
    input  logic                          clk,
    input  logic [`ICACHE_INDEX_W-1:0]    index,
    input  logic                          hit_way,
    input  logic [`ICACHE_BEAT_SEL_W-1:0] word_sel,
    output logic [`ICACHE_WORD_W-1:0]     inst,
    refill_if.array                       refill
);

    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] rd_line;

    // Each beat lands in its own half of the line
    always_ff @(posedge clk) begin
        if (refill.beat_valid) begin
            line_mem[refill.refill_way][refill.refill_index]
                [refill.beat_num * `ICACHE_WORD_W +: `ICACHE_WORD_W] <= refill.beat_data;
        end
    end

    assign rd_line = line_mem[hit_way][index];

    always_ff @(posedge clk) begin
        inst <= rd_line[word_sel * `ICACHE_WORD_W +: `ICACHE_WORD_W];
    end

endmodule

`default_nettype wire

/* source/tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module tag_array (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`ICACHE_INDEX_W-1:0] index,
    input  logic [`ICACHE_TAG_W-1:0]   tag,
    output logic                       hit,
    output logic                       hit_way,
    output logic                       victim_way,
    input  logic                       touch,
    refill_if.array                    refill
);

    logic [`ICACHE_SETS-1:0]  valid_q [`ICACHE_WAYS];
    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    // Least recently used way of each set
    logic [`ICACHE_SETS-1:0]  lru_q;
    logic [`ICACHE_WAYS-1:0]  way_hit;
    logic                     fill;

    assign fill = refill.beat_valid && refill.last_beat;

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // Empty ways first, lowest way first
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (touch && hit) begin
                lru_q[index] <= ~hit_way;
            end
            // A fill makes its way the most recent one
            if (fill) begin
                valid_q[refill.refill_way][refill.refill_index] <= 1'b1;
                lru_q[refill.refill_index]                      <= ~refill.refill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[refill.refill_way][refill.refill_index] <= tag;
        end
    end

endmodule

`default_nettype wire

/* source/refill_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module refill_counter (
    input logic       clk,
    input logic       rst_n,
    refill_if.counter refill
);

    logic [`ICACHE_BEAT_SEL_W-1:0] count_q;

    assign refill.beat_num  = count_q;
    assign refill.last_beat = (int'(count_q) == `ICACHE_BEATS - 1);

    // Back to beat zero once the line is complete
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (refill.beat_valid) begin
            if (refill.last_beat) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_in,
    input  fetch_addr_t               addr,
    input  logic                      hit,
    input  logic                      hit_way,
    input  logic                      victim_way,
    output logic                      busy,
    output logic                      valid_out,
    output logic                      mem_req,
    output logic [63:0]               mem_addr,
    input  logic                      mem_valid,
    input  logic [`ICACHE_WORD_W-1:0] mem_rdata,
    refill_if.ctrl                    refill
);

    ctrl_state_t state_q;
    logic        victim_q;
    logic        replay_hit;
    fetch_addr_t line_addr;

    // Line base keeps tag and index, offset cleared
    always_comb begin
        line_addr          = addr;
        line_addr.f.offset = '0;
    end

    // Memory beats only count while the request is out
    assign refill.beat_valid   = mem_valid && (state_q == REFILL);
    assign refill.beat_data    = mem_rdata;
    assign refill.refill_index = addr.f.index;
    assign refill.refill_way   = victim_q;

    // Replay has to find the line in the way just filled
    assign replay_hit = hit && (hit_way == victim_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            busy      <= 1'b0;
            valid_out <= 1'b0;
            mem_req   <= 1'b0;
            victim_q  <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (valid_in) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        valid_out <= 1'b1;
                        state_q   <= IDLE;
                    end else begin
                        busy     <= 1'b1;
                        victim_q <= victim_way;
                        state_q  <= REQ;
                    end
                end
                REQ: begin
                    mem_req <= 1'b1;
                    state_q <= REFILL;
                end
                REFILL: begin
                    if (refill.beat_valid && refill.last_beat) begin
                        mem_req <= 1'b0;
                        state_q <= REPLAY;
                    end
                end
                REPLAY: begin
                    if (replay_hit) begin
                        valid_out <= 1'b1;
                        busy      <= 1'b0;
                        state_q   <= IDLE;
                    end else begin
                        state_q <= REQ; // fetch the line again
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REQ) begin
            mem_addr <= line_addr.raw;
        end
    end

endmodule

`default_nettype wire

/* source/refill_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

interface refill_if;

    logic                          beat_valid;
    logic [`ICACHE_WORD_W-1:0]     beat_data;
    logic [`ICACHE_BEAT_SEL_W-1:0] beat_num;
    logic                          last_beat;
    logic [`ICACHE_INDEX_W-1:0]    refill_index;
    logic                          refill_way;

    modport ctrl (
        output beat_valid, beat_data, refill_index, refill_way,
        input  last_beat
    );

    modport counter (
        input  beat_valid,
        output beat_num, last_beat
    );

    // Storage only watches the refill traffic
    modport array (
        input beat_valid, beat_data, beat_num, last_beat, refill_index, refill_way
    );

endinterface

`default_nettype wire

/* source/icache_pkg.sv */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Same fetch address, seen either whole or split into fields
    typedef union packed {
        logic [63:0]  raw;
        addr_fields_t f;
    } fetch_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REQ,
        REFILL,
        REPLAY
    } ctrl_state_t;

endpackage

`default_nettype wire

/* include/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Fetch address split into tag, index and byte offset
`define ICACHE_TAG_W      55
`define ICACHE_INDEX_W    6
`define ICACHE_OFFSET_W   3

// Cache geometry
`define ICACHE_SETS       64
`define ICACHE_WAYS       2

// A line arrives as this many 32-bit memory beats
`define ICACHE_BEATS      2
`define ICACHE_WORD_W     32
`define ICACHE_LINE_W     (`ICACHE_WORD_W * `ICACHE_BEATS)

// Selects one word of a line
`define ICACHE_BEAT_SEL_W $clog2(`ICACHE_BEATS)

`endif
